// ==== source/icache_pkg.sv ====
// shared widths, types and structs of the instruction cache, referenced as icache_pkg::name
package icache_pkg;

  //////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////

  localparam int unsigned NUM_WAYS      = 4;
  localparam int unsigned NUM_SETS      = 16;
  localparam int unsigned LINE_BYTES    = 16;
  localparam int unsigned LINE_WIDTH    = LINE_BYTES * 8;
  localparam int unsigned FETCH_WIDTH   = 32;
  localparam int unsigned ADDR_WIDTH    = 32;
  // byte offset inside a line, then set index, rest is tag
  localparam int unsigned OFFSET_WIDTH  = $clog2(LINE_BYTES);
  localparam int unsigned INDEX_WIDTH   = $clog2(NUM_SETS);
  localparam int unsigned TAG_WIDTH     = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int unsigned WAY_IDX_WIDTH = $clog2(NUM_WAYS);
  // replacement lfsr
  localparam int unsigned LFSR_WIDTH    = 8;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  typedef logic [ADDR_WIDTH-1:0]       addr_t;
  typedef logic [TAG_WIDTH-1:0]        tag_t;
  typedef logic [INDEX_WIDTH-1:0]      set_idx_t;
  // word number inside a line, fetches are 32 bit aligned
  typedef logic [OFFSET_WIDTH-3:0]     word_off_t;
  typedef logic [LINE_WIDTH-1:0]       line_t;
  typedef logic [FETCH_WIDTH-1:0]      fetch_word_t;
  typedef logic [WAY_IDX_WIDTH-1:0]    way_idx_t;
  typedef logic [NUM_WAYS-1:0]         way_mask_t;

  //////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////

  typedef enum logic [0:0] {
    RTRN_FILL = 1'b0,
    RTRN_INV  = 1'b1
  } rtrn_type_e;

  typedef enum logic [2:0] {
    FLUSH,
    IDLE,
    LOOKUP,
    REFILL_REQ,
    REFILL_WAIT,
    RESPOND
  } ctrl_state_e;

  //////////////////////////////////////////////////
  // interface structs
  //////////////////////////////////////////////////

  typedef struct packed {
    addr_t addr;
  } fetch_req_t;

  typedef struct packed {
    fetch_word_t word;
  } fetch_rsp_t;

  // line aligned address plus the way the fill will land in
  typedef struct packed {
    addr_t    addr;
    way_idx_t way;
  } refill_req_t;

  // fill data or invalidation, shared return channel
  typedef struct packed {
    rtrn_type_e rtype;
    line_t      data;
    logic       inv_all;
    way_idx_t   inv_way;
    set_idx_t   inv_idx;
  } mem_rtrn_t;

  // one access to the tag/valid/line arrays
  typedef struct packed {
    logic      rd_en;
    logic      wr_en;
    way_mask_t way_mask;
    set_idx_t  set_idx;
    tag_t      tag;
    logic      valid;
  } arr_cmd_t;

endpackage

// ==== source/icache_arrays.sv ====
// tag, valid and line storage of all ways, one synchronous read or write per cycle
`timescale 1ns/1ps

module icache_arrays (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  icache_pkg::arr_cmd_t                       arr_cmd_i,
  input  icache_pkg::line_t                          fill_line_i,
  output icache_pkg::tag_t  [icache_pkg::NUM_WAYS-1:0] tags_o,
  output icache_pkg::way_mask_t                      valid_o,
  output icache_pkg::line_t [icache_pkg::NUM_WAYS-1:0] lines_o
);

  // valid bits of all ways, one entry per set
  icache_pkg::way_mask_t vld_q [icache_pkg::NUM_SETS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < icache_pkg::NUM_SETS; s++) begin
        vld_q[s] <= '0;
      end
      valid_o <= '0;
    end else if (arr_cmd_i.wr_en) begin
      // set on fill, cleared on invalidation and flush
      for (int w = 0; w < icache_pkg::NUM_WAYS; w++) begin
        if (arr_cmd_i.way_mask[w]) begin
          vld_q[arr_cmd_i.set_idx][w] <= arr_cmd_i.valid;
        end
      end
    end else if (arr_cmd_i.rd_en) begin
      valid_o <= vld_q[arr_cmd_i.set_idx];
    end
  end

  //////////////////////////////////////////////////
  // per way tag and line memories
  //////////////////////////////////////////////////

  for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : gen_way
    icache_pkg::tag_t  tag_mem  [icache_pkg::NUM_SETS];
    icache_pkg::line_t line_mem [icache_pkg::NUM_SETS];
    icache_pkg::tag_t  tag_rd_q;
    icache_pkg::line_t line_rd_q;

    always_ff @(posedge clk_i) begin
      // only fills carry a tag and data
      if (arr_cmd_i.wr_en && arr_cmd_i.valid && arr_cmd_i.way_mask[w]) begin
        tag_mem[arr_cmd_i.set_idx]  <= arr_cmd_i.tag;
        line_mem[arr_cmd_i.set_idx] <= fill_line_i;
      end
      if (arr_cmd_i.rd_en) begin
        tag_rd_q  <= tag_mem[arr_cmd_i.set_idx];
        line_rd_q <= line_mem[arr_cmd_i.set_idx];
      end
    end

    assign tags_o[w]  = tag_rd_q;
    assign lines_o[w] = line_rd_q;
  end

  // single port, the controller must never mix the two
  a_no_rd_wr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(arr_cmd_i.rd_en && arr_cmd_i.wr_en))
    else $error("array read and write in one cycle");

endmodule

// ==== source/icache_lookup.sv ====
// tag compare over all ways and fetch word select from the hit line or the fill line
`timescale 1ns/1ps

module icache_lookup (
  input  icache_pkg::tag_t  [icache_pkg::NUM_WAYS-1:0] tags_i,
  input  icache_pkg::way_mask_t                        valid_i,
  input  icache_pkg::line_t [icache_pkg::NUM_WAYS-1:0] lines_i,
  input  icache_pkg::tag_t                             req_tag_i,
  input  icache_pkg::word_off_t                        req_off_i,
  input  icache_pkg::line_t                            fill_line_i,
  input  logic                                         hit_sel_i,
  output icache_pkg::way_mask_t                        hit_o,
  output icache_pkg::fetch_word_t                      word_o
);

  icache_pkg::way_idx_t hit_way;
  icache_pkg::line_t    src_line;

  // valid way with matching tag
  for (genvar w = 0; w < icache_pkg::NUM_WAYS; w++) begin : gen_cmp
    assign hit_o[w] = valid_i[w] && (tags_i[w] == req_tag_i);
  end

  // encode hit way, lowest wins if the mask is ever not one-hot
  always_comb begin
    hit_way = '0;
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (hit_o[w]) begin
        hit_way = icache_pkg::way_idx_t'(w);
      end
    end
  end

  assign src_line = hit_sel_i ? lines_i[hit_way] : fill_line_i;

  // 32 bit word out of the line
  assign word_o = src_line[{req_off_i, 5'b0} +: icache_pkg::FETCH_WIDTH];

endmodule

// ==== source/icache_replace.sv ====
// victim way choice, first invalid way or a pseudo random way, held as index and one-hot mask
`timescale 1ns/1ps

module icache_replace (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  icache_pkg::way_mask_t valid_i,
  input  logic                  take_i,
  input  logic                  step_i,
  output icache_pkg::way_idx_t  victim_way_o,
  output icache_pkg::way_mask_t victim_mask_o
);

  logic [icache_pkg::LFSR_WIDTH-1:0] lfsr_q;
  logic                              lfsr_fb;
  icache_pkg::way_idx_t              inv_way;
  icache_pkg::way_idx_t              pick_way;
  logic                              all_valid;
  logic                              all_valid_q;

  // lowest way with a clear valid bit
  always_comb begin
    inv_way = '0;
    for (int w = icache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_way = icache_pkg::way_idx_t'(w);
      end
    end
  end

  assign all_valid = &valid_i;

  // fibonacci lfsr, x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb  = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  assign pick_way = all_valid ? lfsr_q[icache_pkg::WAY_IDX_WIDTH-1:0] : inv_way;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q        <= {{(icache_pkg::LFSR_WIDTH - 1){1'b0}}, 1'b1};
      all_valid_q   <= 1'b0;
      victim_way_o  <= '0;
      victim_mask_o <= '0;
    end else begin
      // sampled in the compare cycle, held through the refill
      if (take_i) begin
        victim_way_o  <= pick_way;
        victim_mask_o <= icache_pkg::way_mask_t'(1) << pick_way;
        all_valid_q   <= all_valid;
      end
      // advance only when the random way was actually consumed
      if (step_i && all_valid_q) begin
        lfsr_q <= {lfsr_q[icache_pkg::LFSR_WIDTH-2:0], lfsr_fb};
      end
    end
  end

endmodule

// ==== source/icache_ctrl.sv ====
// instruction cache controller, sequences lookup, refill, invalidation and flush over the arrays
`timescale 1ns/1ps

module icache_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  // fetch side
  input  logic                    fetch_valid_i,
  input  icache_pkg::fetch_req_t  fetch_req_i,
  output logic                    fetch_ready_o,
  output logic                    rsp_valid_o,
  output icache_pkg::fetch_rsp_t  rsp_o,
  input  logic                    rsp_ready_i,
  // memory side
  output logic                    refill_valid_o,
  output icache_pkg::refill_req_t refill_req_o,
  input  logic                    refill_ready_i,
  input  logic                    rtrn_valid_i,
  input  icache_pkg::mem_rtrn_t   rtrn_i,
  // lookup and replacement
  input  icache_pkg::way_mask_t   hit_i,
  input  icache_pkg::fetch_word_t word_i,
  input  icache_pkg::way_idx_t    victim_way_i,
  input  icache_pkg::way_mask_t   victim_mask_i,
  output icache_pkg::arr_cmd_t    arr_cmd_o,
  output icache_pkg::tag_t        req_tag_o,
  output icache_pkg::word_off_t   req_off_o,
  output logic                    hit_sel_o,
  output logic                    victim_take_o,
  output logic                    busy_o
);

  icache_pkg::ctrl_state_e state_d, state_q;
  logic                    flush_pend_d, flush_pend_q;
  icache_pkg::set_idx_t    flush_cnt_q;
  logic                    flush_en;
  logic                    flush_done;
  logic                    inv_en;
  logic                    inv_q;
  logic                    fill_en;
  logic                    lookup_rd;
  icache_pkg::set_idx_t    rd_idx;
  icache_pkg::set_idx_t    req_idx;
  logic                    addr_take;
  logic                    word_take;
  icache_pkg::addr_t       addr_q;
  icache_pkg::fetch_word_t rsp_word_q;

  // split the held request address
  assign req_idx   = addr_q[icache_pkg::OFFSET_WIDTH +: icache_pkg::INDEX_WIDTH];
  assign req_tag_o = addr_q[icache_pkg::ADDR_WIDTH-1 -: icache_pkg::TAG_WIDTH];
  assign req_off_o = addr_q[icache_pkg::OFFSET_WIDTH-1:2];

  // return channel decode, fills only count while waiting for one
  assign inv_en  = rtrn_valid_i && (rtrn_i.rtype == icache_pkg::RTRN_INV);
  assign fill_en = rtrn_valid_i && (rtrn_i.rtype == icache_pkg::RTRN_FILL)
                   && (state_q == icache_pkg::REFILL_WAIT);

  assign flush_done = (flush_cnt_q == icache_pkg::set_idx_t'(icache_pkg::NUM_SETS - 1));

  //////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    flush_pend_d   = flush_pend_q | flush_i;
    flush_en       = 1'b0;
    lookup_rd      = 1'b0;
    rd_idx         = req_idx;
    addr_take      = 1'b0;
    word_take      = 1'b0;
    victim_take_o  = 1'b0;
    fetch_ready_o  = 1'b0;
    rsp_valid_o    = 1'b0;
    refill_valid_o = 1'b0;

    unique case (state_q)
      // clear one set per cycle, pending flush is consumed here
      icache_pkg::FLUSH: begin
        flush_en     = 1'b1;
        flush_pend_d = 1'b0;
        if (flush_done) begin
          state_d = icache_pkg::IDLE;
        end
      end
      // an invalidation owns the array port this cycle
      icache_pkg::IDLE: begin
        if (flush_pend_d) begin
          state_d = icache_pkg::FLUSH;
        end else begin
          fetch_ready_o = !inv_en;
          if (fetch_valid_i && !inv_en) begin
            // read all ways with the incoming index at the accepting edge
            lookup_rd = 1'b1;
            rd_idx    = fetch_req_i.addr[icache_pkg::OFFSET_WIDTH +: icache_pkg::INDEX_WIDTH];
            addr_take = 1'b1;
            state_d   = icache_pkg::LOOKUP;
          end
        end
      end
      // compare cycle, defer while invalidations touch the arrays
      icache_pkg::LOOKUP: begin
        if (inv_en) begin
          state_d = icache_pkg::LOOKUP;
        end else if (inv_q) begin
          // read data may predate the last invalidation, read again
          lookup_rd = 1'b1;
        end else if (|hit_i) begin
          word_take = 1'b1;
          state_d   = icache_pkg::RESPOND;
        end else begin
          victim_take_o = 1'b1;
          state_d       = icache_pkg::REFILL_REQ;
        end
      end
      icache_pkg::REFILL_REQ: begin
        refill_valid_o = 1'b1;
        if (refill_ready_i) begin
          state_d = icache_pkg::REFILL_WAIT;
        end
      end
      // word comes straight from the return line
      icache_pkg::REFILL_WAIT: begin
        if (fill_en) begin
          word_take = 1'b1;
          state_d   = icache_pkg::RESPOND;
        end
      end
      icache_pkg::RESPOND: begin
        rsp_valid_o = 1'b1;
        if (rsp_ready_i) begin
          state_d = icache_pkg::IDLE;
        end
      end
      default: begin
        state_d = icache_pkg::FLUSH;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // array command, flush > invalidation > fill > read
  //////////////////////////////////////////////////

  always_comb begin
    arr_cmd_o = '0;
    if (flush_en) begin
      arr_cmd_o.wr_en    = 1'b1;
      arr_cmd_o.way_mask = '1;
      arr_cmd_o.set_idx  = flush_cnt_q;
    end else if (inv_en) begin
      arr_cmd_o.wr_en    = 1'b1;
      arr_cmd_o.way_mask = rtrn_i.inv_all ? '1 : icache_pkg::way_mask_t'(1) << rtrn_i.inv_way;
      arr_cmd_o.set_idx  = rtrn_i.inv_idx;
    end else if (fill_en) begin
      arr_cmd_o.wr_en    = 1'b1;
      arr_cmd_o.way_mask = victim_mask_i;
      arr_cmd_o.set_idx  = req_idx;
      arr_cmd_o.tag      = req_tag_o;
      arr_cmd_o.valid    = 1'b1;
    end else begin
      arr_cmd_o.rd_en    = lookup_rd;
      arr_cmd_o.way_mask = '1;
      arr_cmd_o.set_idx  = rd_idx;
    end
  end

  // hit way during compare, return line otherwise
  assign hit_sel_o = (state_q == icache_pkg::LOOKUP);
  assign busy_o    = (state_q != icache_pkg::IDLE);

  assign rsp_o.word        = rsp_word_q;
  assign refill_req_o.addr = {addr_q[icache_pkg::ADDR_WIDTH-1:icache_pkg::OFFSET_WIDTH],
                              {icache_pkg::OFFSET_WIDTH{1'b0}}};
  assign refill_req_o.way  = victim_way_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= icache_pkg::FLUSH;
      flush_pend_q <= 1'b0;
      flush_cnt_q  <= '0;
      inv_q        <= 1'b0;
    end else begin
      state_q      <= state_d;
      flush_pend_q <= flush_pend_d;
      inv_q        <= inv_en;
      // wraps to zero on the last set
      if (flush_en) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end
    end
  end

  // request address and response word
  always_ff @(posedge clk_i) begin
    if (addr_take) begin
      addr_q <= fetch_req_i.addr;
    end
    if (word_take) begin
      rsp_word_q <= word_i;
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  a_state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {icache_pkg::FLUSH, icache_pkg::IDLE, icache_pkg::LOOKUP,
                    icache_pkg::REFILL_REQ, icache_pkg::REFILL_WAIT, icache_pkg::RESPOND})
    else $error("icache ctrl in illegal state");

  // a fill lands in exactly the one victim way
  a_fill_one_way: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_en |-> $onehot(victim_mask_i))
    else $error("fill write without a single victim way");

  // a tag may live in one way of a set only
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == icache_pkg::LOOKUP && !inv_q && !inv_en) |-> $onehot0(hit_i))
    else $error("multiple ways hit");

endmodule

// ==== source/icache_top.sv ====
// four way set associative instruction cache top, fetch port in, single line refill port out
`timescale 1ns/1ps

module icache_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    flush_i,
  // fetch requests and responses
  input  logic                    fetch_valid_i,
  input  icache_pkg::fetch_req_t  fetch_req_i,
  output logic                    fetch_ready_o,
  output logic                    rsp_valid_o,
  output icache_pkg::fetch_rsp_t  rsp_o,
  input  logic                    rsp_ready_i,
  // line refill and return channel
  output logic                    refill_valid_o,
  output icache_pkg::refill_req_t refill_req_o,
  input  logic                    refill_ready_i,
  input  logic                    rtrn_valid_i,
  input  icache_pkg::mem_rtrn_t   rtrn_i,
  output logic                    busy_o
);

  icache_pkg::arr_cmd_t                        arr_cmd;
  icache_pkg::tag_t  [icache_pkg::NUM_WAYS-1:0] tags;
  icache_pkg::way_mask_t                       valid;
  icache_pkg::line_t [icache_pkg::NUM_WAYS-1:0] lines;
  icache_pkg::tag_t                            req_tag;
  icache_pkg::word_off_t                       req_off;
  logic                                        hit_sel;
  icache_pkg::way_mask_t                       hit;
  icache_pkg::fetch_word_t                     word;
  logic                                        victim_take;
  icache_pkg::way_idx_t                        victim_way;
  icache_pkg::way_mask_t                       victim_mask;

  icache_ctrl i_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_ready_o  (fetch_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_o          (rsp_o),
    .rsp_ready_i    (rsp_ready_i),
    .refill_valid_o (refill_valid_o),
    .refill_req_o   (refill_req_o),
    .refill_ready_i (refill_ready_i),
    .rtrn_valid_i   (rtrn_valid_i),
    .rtrn_i         (rtrn_i),
    .hit_i          (hit),
    .word_i         (word),
    .victim_way_i   (victim_way),
    .victim_mask_i  (victim_mask),
    .arr_cmd_o      (arr_cmd),
    .req_tag_o      (req_tag),
    .req_off_o      (req_off),
    .hit_sel_o      (hit_sel),
    .victim_take_o  (victim_take),
    .busy_o         (busy_o)
  );

  icache_arrays i_arrays (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .arr_cmd_i   (arr_cmd),
    .fill_line_i (rtrn_i.data),
    .tags_o      (tags),
    .valid_o     (valid),
    .lines_o     (lines)
  );

  icache_lookup i_lookup (
    .tags_i      (tags),
    .valid_i     (valid),
    .lines_i     (lines),
    .req_tag_i   (req_tag),
    .req_off_i   (req_off),
    .fill_line_i (rtrn_i.data),
    .hit_sel_i   (hit_sel),
    .hit_o       (hit),
    .word_o      (word)
  );

  // only fill writes carry a set valid bit, so it marks the lfsr step
  icache_replace i_replace (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .valid_i       (valid),
    .take_i        (victim_take),
    .step_i        (arr_cmd.valid),
    .victim_way_o  (victim_way),
    .victim_mask_o (victim_mask)
  );

endmodule

// ==== tests/icache_tb.sv ====
// testbench for icache_top, replays tests/icache_tests.txt against a line memory model
`timescale 1ns/1ps

module icache_tb;

  // one operation from the data file
  typedef struct packed {
    logic [7:0]  code;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] word;
    logic        miss;
  } op_t;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    flush_i;
  logic                    fetch_valid_i;
  icache_pkg::fetch_req_t  fetch_req_i;
  logic                    fetch_ready_o;
  logic                    rsp_valid_o;
  icache_pkg::fetch_rsp_t  rsp_o;
  logic                    rsp_ready_i;
  logic                    refill_valid_o;
  icache_pkg::refill_req_t refill_req_o;
  logic                    refill_ready_i;
  logic                    rtrn_valid_i;
  icache_pkg::mem_rtrn_t   rtrn_i;
  logic                    busy_o;

  logic [31:0] lfsr_q;
  op_t         ops_q[$];
  int          n_ops;

  // valid bits the cache should hold, per set
  icache_pkg::way_mask_t vld_model[icache_pkg::NUM_SETS];

  icache_top i_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_req_i    (fetch_req_i),
    .fetch_ready_o  (fetch_ready_o),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_o          (rsp_o),
    .rsp_ready_i    (rsp_ready_i),
    .refill_valid_o (refill_valid_o),
    .refill_req_o   (refill_req_o),
    .refill_ready_i (refill_ready_i),
    .rtrn_valid_i   (rtrn_valid_i),
    .rtrn_i         (rtrn_i),
    .busy_o         (busy_o)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic stop_run();
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERR %0t %s actual %h expected %h", $time, name, actual, expected);
      stop_run();
    end
  endtask

  // 32 bit fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // one lfsr step per bit taken
  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  // lowest way not yet filled in the set
  function automatic icache_pkg::way_idx_t lowest_free(input icache_pkg::way_mask_t m);
    icache_pkg::way_idx_t way;
    logic                 found;
    way   = '0;
    found = 1'b0;
    for (int w = 0; w < int'(icache_pkg::NUM_WAYS); w++) begin
      if (!found && !m[w]) begin
        way   = icache_pkg::way_idx_t'(w);
        found = 1'b1;
      end
    end
    return way;
  endfunction

  // memory content, word at byte address a is a ^ 5a5a0000
  function automatic icache_pkg::line_t make_line(input icache_pkg::addr_t base);
    icache_pkg::line_t line;
    icache_pkg::addr_t a;
    line = '0;
    for (int k = 0; k < int'(icache_pkg::LINE_BYTES / 4); k++) begin
      a = base + icache_pkg::addr_t'(4 * k);
      line[32*k +: 32] = a ^ 32'h5a5a0000;
    end
    return line;
  endfunction

  task automatic load_ops();
    int          fd;
    int          rc;
    int          n;
    string       line;
    logic [7:0]  code;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] w;
    logic [31:0] m;
    op_t         entry;
    fd = $fopen("tests/icache_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open tests/icache_tests.txt");
      stop_run();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc   = $fgets(line, fd);
        // skip comments and blank lines
        if (rc != 0 && line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h %h", code, a, b, w, m);
          if (n != 5) begin
            $display("malformed line in operation file: %s", line);
            stop_run();
          end
          entry = '{code: code, a: a, b: b, word: w, miss: m[0]};
          ops_q.push_back(entry);
        end
      end
      $fclose(fd);
    end
  endtask

  // counts flush cycles, fetch port stays closed meanwhile
  task automatic wait_flush();
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    while (busy_o) begin
      check_value("fetch_ready_o", 32'(fetch_ready_o), 32'd0);
      cycles++;
      @(posedge clk_i);
    end
    check_value("flush cycles", 32'(cycles), 32'(icache_pkg::NUM_SETS));
  endtask

  //////////////////////////////////////////////////
  // operations
  //////////////////////////////////////////////////

  task automatic run_fetch(input icache_pkg::addr_t addr, input logic [31:0] exp_word,
                           input logic exp_miss);
    logic [31:0]             rnd;
    logic [31:0]             stall;
    logic [31:0]             fill_wait;
    logic                    fill_pend;
    logic                    missed;
    int                      lat;
    int                      fill_edge;
    icache_pkg::addr_t       line_addr;
    icache_pkg::set_idx_t    set_idx;
    icache_pkg::fetch_word_t held;
    take_bits(2, stall);
    missed    = 1'b0;
    fill_pend = 1'b0;
    fill_wait = '0;
    lat       = 0;
    fill_edge = -1;
    line_addr = addr & ~32'(icache_pkg::LINE_BYTES - 1);
    set_idx   = addr[icache_pkg::OFFSET_WIDTH +: icache_pkg::INDEX_WIDTH];
    @(negedge clk_i);
    fetch_valid_i    = 1'b1;
    fetch_req_i.addr = addr;
    // zero stall means ready before the response shows up
    rsp_ready_i      = (stall == 0);
    do begin
      @(posedge clk_i);
    end while (!fetch_ready_o);
    // edges counted from the accepting edge
    do begin
      @(negedge clk_i);
      fetch_valid_i = 1'b0;
      rtrn_valid_i  = 1'b0;
      if (fill_pend) begin
        if (fill_wait == 0) begin
          rtrn_i.rtype   = icache_pkg::RTRN_FILL;
          rtrn_i.data    = make_line(line_addr);
          rtrn_i.inv_all = 1'b0;
          rtrn_i.inv_way = '0;
          rtrn_i.inv_idx = '0;
          rtrn_valid_i   = 1'b1;
          fill_pend      = 1'b0;
          fill_edge      = lat + 1;
        end else begin
          fill_wait = fill_wait - 1;
        end
      end
      take_bits(1, rnd);
      refill_ready_i = rnd[0];
      @(posedge clk_i);
      lat++;
      if (refill_valid_o && refill_ready_i) begin
        check_value("refill_req_o.addr", refill_req_o.addr, line_addr);
        // invalid ways fill first, the random pick is taken as reported
        if (vld_model[set_idx] != '1) begin
          check_value("refill_req_o.way", 32'(refill_req_o.way),
                      32'(lowest_free(vld_model[set_idx])));
        end
        vld_model[set_idx][refill_req_o.way] = 1'b1;
        missed    = 1'b1;
        fill_pend = 1'b1;
        take_bits(2, fill_wait);
      end
    end while (!rsp_valid_o);
    check_value("refill issued", 32'(missed), 32'(exp_miss));
    if (missed) begin
      check_value("rsp_valid_o after fill", 32'(lat - fill_edge), 32'd1);
    end else begin
      check_value("rsp_valid_o hit latency", 32'(lat), 32'd2);
    end
    held = rsp_o.word;
    check_value("rsp_o", held, exp_word);
    // back-pressure, response must hold
    while (!rsp_ready_i) begin
      @(negedge clk_i);
      refill_ready_i = 1'b0;
      if (stall == 1) begin
        rsp_ready_i = 1'b1;
      end else begin
        stall = stall - 1;
      end
      @(posedge clk_i);
      check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd1);
      check_value("rsp_o", rsp_o.word, held);
    end
    @(negedge clk_i);
    rsp_ready_i    = 1'b0;
    refill_ready_i = 1'b0;
  endtask

  task automatic send_inv(input icache_pkg::set_idx_t set, input icache_pkg::way_idx_t way,
                          input logic all_ways);
    if (all_ways) begin
      vld_model[set] = '0;
    end else begin
      vld_model[set][way] = 1'b0;
    end
    @(negedge clk_i);
    rtrn_i.rtype   = icache_pkg::RTRN_INV;
    rtrn_i.data    = '0;
    rtrn_i.inv_all = all_ways;
    rtrn_i.inv_way = way;
    rtrn_i.inv_idx = set;
    rtrn_valid_i   = 1'b1;
    @(negedge clk_i);
    rtrn_valid_i   = 1'b0;
  endtask

  task automatic run_flush();
    foreach (vld_model[s]) begin
      vld_model[s] = '0;
    end
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    wait_flush();
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    flush_i        = 1'b0;
    fetch_valid_i  = 1'b0;
    fetch_req_i    = '0;
    rsp_ready_i    = 1'b0;
    refill_ready_i = 1'b0;
    rtrn_valid_i   = 1'b0;
    rtrn_i         = '0;
    lfsr_q         = 32'h3d23;
    foreach (vld_model[s]) begin
      vld_model[s] = '0;
    end
    load_ops();
    if (ops_q.size() == 0) begin
      $display("operation file holds no operations");
      stop_run();
    end
    n_ops = ops_q.size();
    // two cycles of reset
    repeat (2) @(negedge clk_i);
    check_value("fetch_ready_o", 32'(fetch_ready_o), 32'd0);
    check_value("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
    check_value("refill_valid_o", 32'(refill_valid_o), 32'd0);
    check_value("busy_o", 32'(busy_o), 32'd1);
    rst_ni = 1'b1;
    // self clear after reset
    wait_flush();
    foreach (ops_q[i]) begin
      case (ops_q[i].code)
        "F": run_fetch(ops_q[i].a, ops_q[i].word, ops_q[i].miss);
        "I": send_inv(ops_q[i].a[3:0], ops_q[i].b[1:0], 1'b0);
        "A": send_inv(ops_q[i].a[3:0], 2'd0, 1'b1);
        "X": run_flush();
        default: begin
          $display("unknown opcode %c in operation %0d", ops_q[i].code, i);
          stop_run();
        end
      endcase
    end
    $display("all tests passed");
    $finish;
  end

  // limit grows with the operation count
  initial begin : watchdog
    wait (n_ops > 0);
    repeat (n_ops * 200) @(posedge clk_i);
    $display("watchdog expired before all operations completed");
    stop_run();
  end

endmodule

// ==== build.f ====
source/icache_pkg.sv
source/icache_arrays.sv
source/icache_lookup.sv
source/icache_replace.sv
source/icache_ctrl.sv
source/icache_top.sv
tests/icache_tb.sv

// ==== Makefile ====
# Verilator flow for the instruction cache, run from the project root

TOP := icache_tb

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "all tests passed" sim.log

obj_dir/V$(TOP): build.f $(wildcard source/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// ==== tests/icache_tests.txt ====
# op a b word miss: op F fetch, I invalidate way, A invalidate set, X flush
# a is the fetch address or the set, b the way, word and miss are expected for F
F 00001000 0 5a5a1000 1
F 00001004 0 5a5a1004 0
F 0000100c 0 5a5a100c 0
F 12342014 0 486e2014 1
F 12342018 0 486e2018 0
F 80003028 0 da5a3028 1
F 8000302c 0 da5a302c 0
# single way and whole set invalidation
I 0 0 00000000 0
F 00001008 0 5a5a1008 1
F 00001000 0 5a5a1000 0
I 1 1 00000000 0
F 1234201c 0 486e201c 0
A 2 0 00000000 0
F 80003024 0 da5a3024 1
F 80003020 0 da5a3020 0
# flush drops every line
X 0 0 00000000 0
F 00001004 0 5a5a1004 1
F 12342010 0 486e2010 1
F 80003028 0 da5a3028 1
F 12342010 0 486e2010 0
# five tags in set 5
F abcd0150 0 f1970150 1
F 00000254 0 5a5a0254 1
F 7fff0358 0 25a50358 1
F c0de045c 0 9a84045c 1
F abcd0154 0 f1970154 0
F 00000258 0 5a5a0258 0
F 7fff035c 0 25a5035c 0
F c0de0450 0 9a840450 0
F 5a5a0550 0 00000550 1
F 5a5a055c 0 0000055c 0
# mixed traffic
F 0000100c 0 5a5a100c 0
A 5 0 00000000 0
F 5a5a0554 0 00000554 1
F fffffff0 0 a5a5fff0 1
F fffffffc 0 a5a5fffc 0
F 1234201c 0 486e201c 0
F 80003020 0 da5a3020 0
